/* build.f */
rv_isa_pkg.sv
rv_ctrl_pkg.sv
singlecycle_control.sv
imm_generator.sv
execute_unit.sv
exec_stage.sv
exec_asserts.sv
exec_checker.sv
tb_exec_stage.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - rv_isa_pkg.sv
  - rv_ctrl_pkg.sv
  - singlecycle_control.sv
  - imm_generator.sv
  - execute_unit.sv
  - exec_stage.sv
  - target: test
    files:
      - exec_asserts.sv
      - exec_checker.sv
      - tb_exec_stage.sv

/* tb_exec_stage.sv */
/*
 * Testbench for the RV32I execute stage. Drives random requests under
 * random back-pressure and reports the verdict from the checker counts.
 */

`timescale 1ns/100ps

module tb_exec_stage;

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  localparam int NUM_TXN    = 400;
  localparam int BURST_TXN  = 40;                  // opening run with res_ready high.
  localparam int MAX_CYCLES = NUM_TXN * 20 + 200;

  logic        clock;
  logic        arst_n;
  exec_req_t   req;
  logic        req_valid;
  logic        req_ready;
  exec_res_t   res;
  logic        res_valid;
  logic        res_ready;
  logic        took;
  logic [31:0] lcg_state;
  logic [31:0] r;
  int          sent;
  int          value_errors;
  int          other_errors;
  int          results;

  exec_stage DUT
  (
    .clock     (clock),
    .arst_n    (arst_n),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  exec_checker u_checker
  (
    .clock        (clock),
    .arst_n       (arst_n),
    .req          (req),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .res          (res),
    .res_valid    (res_valid),
    .res_ready    (res_ready),
    .value_errors (value_errors),
    .other_errors (other_errors),
    .results      (results)
  );

  bind exec_stage exec_asserts u_asserts
  (
    .clock     (clock),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .res       (res),
    .res_valid (res_valid),
    .res_ready (res_ready)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // mostly legal opcodes weighted toward ALU and branch.
  function automatic logic [6:0] pick_opcode();
    logic [31:0] v;
    logic [6:0]  opc;
    v = lcg_next();
    case (v[31:28])
      4'd0:               opc = OPC_LOAD;
      4'd1:               opc = OPC_MISC_MEM;
      4'd2, 4'd11:        opc = OPC_OP_IMM;
      4'd3:               opc = OPC_AUIPC;
      4'd4:               opc = OPC_STORE;
      4'd5, 4'd10, 4'd13: opc = OPC_OP;
      4'd6:               opc = OPC_LUI;
      4'd7, 4'd12, 4'd14: opc = OPC_BRANCH;
      4'd8:               opc = OPC_JALR;
      4'd9:               opc = OPC_JAL;
      default:
      begin
        opc = v[22:16];
        if (opc inside {OPC_LOAD, OPC_MISC_MEM, OPC_OP_IMM, OPC_AUIPC, OPC_STORE,
                        OPC_OP, OPC_LUI, OPC_BRANCH, OPC_JALR, OPC_JAL})
          opc = 7'b1110011; // the system opcode is unknown to this stage.
      end
    endcase
    return opc;
  endfunction

  task automatic new_request();
    logic [31:0] inst;
    logic [31:0] v;
    inst      = lcg_next();
    inst[6:0] = pick_opcode();
    if (inst[6:0] == OPC_BRANCH && inst[14:13] == 2'b01)
      inst[14] = 1'b1; // reserved branch funct3 moved to bltu/bgeu.
    req.inst     = inst;
    v            = lcg_next();
    req.pc       = {v[31:2], 2'b00};
    req.rs1_data = lcg_next();
    v            = lcg_next();
    req.rs2_data = (v[31:30] == 2'b00) ? req.rs1_data : lcg_next();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // clock, stimulus and verdict.
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock)
    took <= req_valid && req_ready;

  initial
  begin
    lcg_state = 32'ha241;
    arst_n    = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    res_ready = 1'b0;
    sent      = 0;
    repeat (4) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
    while (results < NUM_TXN)
    begin
      @(negedge clock);
      r         = lcg_next();
      res_ready = (sent <= BURST_TXN) ? 1'b1 : (r[31:30] != 2'b00);
      if (!req_valid || took)
      begin
        if (sent < NUM_TXN && (sent < BURST_TXN || r[27:26] != 2'b00))
        begin
          new_request();
          req_valid = 1'b1;
          sent++;
        end
        else
          req_valid = 1'b0;
      end
    end
    req_valid = 1'b0;
    repeat (3) @(negedge clock);
    $display("value errors %0d, other errors %0d, assertion failures %0d, results %0d of %0d",
             value_errors, other_errors, DUT.u_asserts.fails, results, NUM_TXN);
    if (value_errors == 0 && other_errors == 0 && DUT.u_asserts.fails == 0 &&
        results == NUM_TXN)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // watchdog.
  initial
  begin
    #(MAX_CYCLES * 10);
    $display("the stage stalled, only %0d of %0d results arrived before the time limit",
             results, NUM_TXN);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

/* exec_checker.sv */
/*
 * Execute stage checker. Predicts each accepted request with an RV32I
 * reference model and compares the results in order as they leave.
 */

`timescale 1ns/100ps

module exec_checker
(
  input  logic                    clock,
  input  logic                    arst_n,
  input  rv_ctrl_pkg::exec_req_t  req,
  input  logic                    req_valid,
  input  logic                    req_ready,
  input  rv_ctrl_pkg::exec_res_t  res,
  input  logic                    res_valid,
  input  logic                    res_ready,
  output int                      value_errors,
  output int                      other_errors,
  output int                      results
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  exec_res_t expected_q[$];
  exec_res_t exp_res;
  logic      accepted_last;

  // integer op by funct3, alt picks sub or arithmetic shift.
  function automatic logic [31:0] alu_model(logic [31:0] a, logic [31:0] b,
                                            logic [2:0] f3, logic alt);
    logic [63:0] ext;
    logic        lt_s;
    ext  = {{32{a[31]}}, a} >> b[4:0];
    lt_s = (a[31] != b[31]) ? a[31] : (a < b); // signs differ, negative one is less.
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'd0, lt_s};
      3'b011:  return {31'd0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? ext[31:0] : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic exec_res_t reference_result(exec_req_t r);
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] pc4;
    logic [31:0] slt;
    logic [2:0]  f3;
    logic        is_op;
    logic        taken;
    exec_res_t   e;
    f3    = r.inst[14:12];
    is_op = (r.inst[6:0] == OPC_OP);
    imm_i = {{20{r.inst[31]}}, r.inst[31:20]};
    imm_s = {{20{r.inst[31]}}, r.inst[31:25], r.inst[11:7]};
    imm_b = {{19{r.inst[31]}}, r.inst[31], r.inst[7], r.inst[30:25], r.inst[11:8], 1'b0};
    imm_u = {r.inst[31:12], 12'h000};
    imm_j = {{11{r.inst[31]}}, r.inst[31], r.inst[19:12], r.inst[20], r.inst[30:21], 1'b0};
    pc4   = r.pc + 32'd4;
    e            = '0;
    e.next_pc    = pc4;
    e.rd_addr    = r.inst[11:7];
    e.store_data = r.rs2_data;
    case (r.inst[6:0])
      OPC_OP, OPC_OP_IMM:
      begin
        e.rd_we   = 1'b1;
        e.wb_data = alu_model(r.rs1_data, is_op ? r.rs2_data : imm_i, f3,
                              r.inst[30] && (is_op || f3 == 3'b101));
      end
      OPC_LOAD:
      begin
        e.rd_we    = 1'b1;
        e.mem_re   = 1'b1;
        e.mem_addr = r.rs1_data + imm_i; // no load data comes back.
      end
      OPC_STORE:
      begin
        e.mem_we   = 1'b1;
        e.mem_addr = r.rs1_data + imm_s;
      end
      OPC_LUI:
      begin
        e.rd_we   = 1'b1;
        e.wb_data = imm_u;
      end
      OPC_AUIPC:
      begin
        e.rd_we   = 1'b1;
        e.wb_data = r.pc + imm_u;
      end
      OPC_JAL:
      begin
        e.rd_we   = 1'b1;
        e.wb_data = pc4;
        e.next_pc = r.pc + imm_j;
      end
      OPC_JALR:
      begin
        e.rd_we   = 1'b1;
        e.wb_data = pc4;
        e.next_pc = (r.rs1_data + imm_i) & ~32'd1;
      end
      OPC_BRANCH:
      begin
        slt = alu_model(r.rs1_data, r.rs2_data, 3'b010, 1'b0);
        case (f3)
          3'b000:  taken = (r.rs1_data == r.rs2_data);
          3'b001:  taken = (r.rs1_data != r.rs2_data);
          3'b100:  taken = slt[0];
          3'b101:  taken = !slt[0];
          3'b110:  taken = (r.rs1_data < r.rs2_data);
          3'b111:  taken = (r.rs1_data >= r.rs2_data);
          default: taken = 1'b0;
        endcase
        if (taken)
          e.next_pc = r.pc + imm_b;
      end
      OPC_MISC_MEM: e.illegal = 1'b0; // fence does nothing.
      default:      e.illegal = 1'b1;
    endcase
    e.rd_we = e.rd_we && (e.rd_addr != 5'd0);
    return e;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic compare_result(input exec_res_t e);
    check_field("res.next_pc", res.next_pc, e.next_pc);
    check_field("res.rd_addr", res.rd_addr, e.rd_addr);
    check_field("res.rd_we", res.rd_we, e.rd_we);
    check_field("res.mem_re", res.mem_re, e.mem_re);
    check_field("res.mem_we", res.mem_we, e.mem_we);
    check_field("res.illegal", res.illegal, e.illegal);
    if (e.rd_we)
      check_field("res.wb_data", res.wb_data, e.wb_data);
    if (e.mem_re || e.mem_we)
      check_field("res.mem_addr", res.mem_addr, e.mem_addr);
    if (e.mem_we)
      check_field("res.store_data", res.store_data, e.store_data);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // scoreboard.
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    value_errors = 0;
    other_errors = 0;
    results      = 0;
  end

  always @(posedge clock)
  begin
    if (!arst_n)
      accepted_last = 1'b0;
    else
    begin
      if (accepted_last && !res_valid)
      begin
        $display("no result appeared one cycle after an accepted request");
        other_errors++;
      end
      if (res_valid && res_ready)
      begin
        if (expected_q.size() == 0)
        begin
          $display("a result left the stage with no request outstanding");
          other_errors++;
        end
        else
        begin
          exp_res = expected_q.pop_front();
          compare_result(exp_res);
        end
        results++;
      end
      accepted_last = req_valid && req_ready;
      if (req_valid && req_ready)
        expected_q.push_back(reference_result(req)); // leaves on a later edge.
    end
  end

endmodule

/* exec_asserts.sv */
/*
 * Handshake and reset assertions for the execute stage, bound onto the top.
 */

`timescale 1ns/100ps

module exec_asserts
(
  input  logic                    clock,
  input  logic                    arst_n,
  input  logic                    req_valid,
  input  logic                    req_ready,
  input  rv_ctrl_pkg::exec_res_t  res,
  input  logic                    res_valid,
  input  logic                    res_ready
);

  int fails = 0; // failures seen so far.

  // a stalled result holds its value.
  stall_hold: assert property (@(posedge clock) disable iff (!arst_n)
    res_valid && !res_ready |=> res_valid && $stable(res))
  else
  begin
    fails++;
    $error("result dropped or changed while stalled");
  end

  ready_rule: assert property (@(posedge clock) disable iff (!arst_n)
    req_ready == (res_ready || !res_valid))
  else
  begin
    fails++;
    $error("req_ready does not follow res_ready and res_valid");
  end

  accept_to_valid: assert property (@(posedge clock) disable iff (!arst_n)
    req_valid && req_ready |=> res_valid)
  else
  begin
    fails++;
    $error("no result one cycle after an accepted request");
  end

  reset_clear: assert property (@(posedge clock) !arst_n |-> !res_valid)
  else
  begin
    fails++;
    $error("res_valid high during reset");
  end

endmodule

/* exec_stage.sv */
/*
 * RV32I execute stage top. Decoder and immediate generator run side by side
 * and feed the execute unit, which registers the result.
 */

`timescale 1ns/100ps

module exec_stage
(
  input  logic                    clock,
  input  logic                    arst_n,
  input  rv_ctrl_pkg::exec_req_t  req,
  input  logic                    req_valid,
  output logic                    req_ready,
  output rv_ctrl_pkg::exec_res_t  res,
  output logic                    res_valid,
  input  logic                    res_ready
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  ctrl_t           ctrl;
  logic [XLEN-1:0] imm;
  logic            take_branch; // feeds back only into pc_sel.

  singlecycle_control u_control
  (
    .inst_opcode (req.inst[6:0]),
    .take_branch (take_branch),
    .ctrl        (ctrl)
  );

  imm_generator u_imm_gen
  (
    .inst (req.inst),
    .imm  (imm)
  );

  execute_unit u_execute
  (
    .clock       (clock),
    .arst_n      (arst_n),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .ctrl        (ctrl),
    .imm         (imm),
    .take_branch (take_branch),
    .res         (res),
    .res_valid   (res_valid),
    .res_ready   (res_ready)
  );

endmodule

/* execute_unit.sv */
/*
 * Execute unit. Runs the ALU and branch compare, forms next pc, writeback
 * value and memory request, and holds the result in a one-entry register.
 */

`timescale 1ns/100ps

module execute_unit
(
  input  logic                         clock,
  input  logic                         arst_n,
  input  rv_ctrl_pkg::exec_req_t       req,
  input  logic                         req_valid,
  output logic                         req_ready,
  input  rv_ctrl_pkg::ctrl_t           ctrl,
  input  logic [rv_isa_pkg::XLEN-1:0]  imm,
  output logic                         take_branch,
  output rv_ctrl_pkg::exec_res_t       res,
  output logic                         res_valid,
  input  logic                         res_ready
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [2:0]      funct3;
  logic            funct7_b5;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_out;
  logic [XLEN-1:0] pc4;
  logic [XLEN-1:0] pc_target;
  alu_op_e         alu_op;
  exec_res_t       res_d;

  assign funct3    = req.inst[14:12];
  assign funct7_b5 = req.inst[30];

  ////////////////////////////////////////////////////////////////////////////
  // ALU.
  ////////////////////////////////////////////////////////////////////////////

  assign op_a = (ctrl.alu_a_sel == A_PC)  ? req.pc : req.rs1_data;
  assign op_b = (ctrl.alu_b_sel == B_IMM) ? imm    : req.rs2_data;

  always_comb
  begin
    alu_op = ALU_ADD;
    case (ctrl.alu_ctl)
      CTL_OP, CTL_OP_IMM:
      begin
        case (funct3)
          F3_ADD_SUB: alu_op = (ctrl.alu_ctl == CTL_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
          F3_SLL:     alu_op = ALU_SLL;
          F3_SLT:     alu_op = ALU_SLT;
          F3_SLTU:    alu_op = ALU_SLTU;
          F3_XOR:     alu_op = ALU_XOR;
          F3_SRL_SRA: alu_op = funct7_b5 ? ALU_SRA : ALU_SRL; // srai keeps bit 30 too.
          F3_OR:      alu_op = ALU_OR;
          default:    alu_op = ALU_AND;
        endcase
      end
      CTL_BRANCH: alu_op = ALU_SUB; // compare is done below.
      default:    alu_op = ALU_ADD;
    endcase
  end

  always_comb
  begin
    case (alu_op)
      ALU_SUB:  alu_out = op_a - op_b;
      ALU_SLL:  alu_out = op_a << op_b[4:0];
      ALU_SLT:  alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_out = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_XOR:  alu_out = op_a ^ op_b;
      ALU_SRL:  alu_out = op_a >> op_b[4:0];
      ALU_SRA:  alu_out = $unsigned($signed(op_a) >>> op_b[4:0]);
      ALU_OR:   alu_out = op_a | op_b;
      ALU_AND:  alu_out = op_a & op_b;
      default:  alu_out = op_a + op_b;
    endcase
  end

  // branch condition, only consumed by the decoder for BRANCH.
  always_comb
  begin
    case (funct3)
      F3_BEQ:  take_branch = (req.rs1_data == req.rs2_data);
      F3_BNE:  take_branch = (req.rs1_data != req.rs2_data);
      F3_BLT:  take_branch = ($signed(req.rs1_data) < $signed(req.rs2_data));
      F3_BGE:  take_branch = ($signed(req.rs1_data) >= $signed(req.rs2_data));
      F3_BLTU: take_branch = (req.rs1_data < req.rs2_data);
      F3_BGEU: take_branch = (req.rs1_data >= req.rs2_data);
      default: take_branch = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // result fields.
  ////////////////////////////////////////////////////////////////////////////

  assign pc4       = req.pc + 32'd4;
  assign pc_target = req.pc + imm; // branch and jal target.

  always_comb
  begin
    case (ctrl.pc_sel)
      PC_PC_IMM:  res_d.next_pc = pc_target;
      PC_RS1_IMM: res_d.next_pc = {alu_out[XLEN-1:1], 1'b0}; // jalr drops bit 0.
      default:    res_d.next_pc = pc4;
    endcase

    case (ctrl.wb_sel)
      WB_DATA: res_d.wb_data = '0;
      WB_IMM:  res_d.wb_data = imm;
      WB_PC4:  res_d.wb_data = pc4;
      default: res_d.wb_data = alu_out;
    endcase

    res_d.rd_addr    = req.inst[11:7];
    res_d.rd_we      = ctrl.reg_we && (req.inst[11:7] != 5'd0); // x0 is never written.
    res_d.mem_addr   = alu_out;
    res_d.store_data = req.rs2_data;
    res_d.mem_re     = ctrl.mem_re;
    res_d.mem_we     = ctrl.mem_we;
    res_d.illegal    = ctrl.illegal;
  end

  ////////////////////////////////////////////////////////////////////////////
  // output register.
  ////////////////////////////////////////////////////////////////////////////

  assign req_ready = res_ready | ~res_valid; // free or draining this edge.

  always_ff @(posedge clock or negedge arst_n)
  begin
    if (!arst_n)
      res_valid <= 1'b0;
    else if (req_ready)
      res_valid <= req_valid;
  end

  always_ff @(posedge clock)
  begin
    if (req_valid && req_ready)
      res <= res_d;
  end

endmodule

/* imm_generator.sv */
/*
 * Immediate generator. Picks the I/S/B/U/J format from the opcode and
 * sign-extends the immediate to the data width.
 */

`timescale 1ns/100ps

module imm_generator
(
  input  logic [31:0]                  inst,
  output logic [rv_isa_pkg::XLEN-1:0]  imm
);

  import rv_isa_pkg::*;

  always_comb
  begin
    case (inst[6:0])
      OPC_LOAD, OPC_OP_IMM, OPC_JALR:
        imm = {{21{inst[31]}}, inst[30:20]};                               // i-type.
      OPC_STORE:
        imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};                   // s-type.
      OPC_BRANCH:
        imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};    // b-type.
      OPC_LUI, OPC_AUIPC:
        imm = {inst[31:12], 12'b0};                                        // u-type.
      OPC_JAL:
        imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};  // j-type.
      default:
        imm = '0;
    endcase
  end

endmodule

/* singlecycle_control.sv */
/*
 * Single-cycle main decoder. Maps the major opcode onto the control bundle
 * and picks the next-pc source from the branch outcome.
 */

`timescale 1ns/100ps

module singlecycle_control
(
  input  logic [6:0]          inst_opcode,
  input  logic                take_branch,
  output rv_ctrl_pkg::ctrl_t  ctrl
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // next pc select.
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (inst_opcode)
      OPC_BRANCH: ctrl.pc_sel = take_branch ? PC_PC_IMM : PC_PC4;
      OPC_JALR:   ctrl.pc_sel = PC_RS1_IMM;
      OPC_JAL:    ctrl.pc_sel = PC_PC_IMM;
      default:    ctrl.pc_sel = PC_PC4; // unknown opcodes fall through too.
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // datapath controls.
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    // quiet defaults, nothing written.
    ctrl.reg_we    = 1'b0;
    ctrl.alu_a_sel = A_RS1;
    ctrl.alu_b_sel = B_RS2;
    ctrl.alu_ctl   = CTL_ADD;
    ctrl.mem_re    = 1'b0;
    ctrl.mem_we    = 1'b0;
    ctrl.wb_sel    = WB_ALU;
    ctrl.illegal   = 1'b0;

    case (inst_opcode)
      OPC_LOAD:
      begin
        ctrl.reg_we    = 1'b1;
        ctrl.alu_b_sel = B_IMM;     // rs1 + offset.
        ctrl.mem_re    = 1'b1;
        ctrl.wb_sel    = WB_DATA;
      end
      OPC_MISC_MEM:
      begin
        // fence has no effect here.
      end
      OPC_OP_IMM:
      begin
        ctrl.reg_we    = 1'b1;
        ctrl.alu_b_sel = B_IMM;
        ctrl.alu_ctl   = CTL_OP_IMM;
      end
      OPC_AUIPC:
      begin
        ctrl.reg_we    = 1'b1;
        ctrl.alu_a_sel = A_PC;
        ctrl.alu_b_sel = B_IMM;
      end
      OPC_STORE:
      begin
        ctrl.alu_b_sel = B_IMM;
        ctrl.mem_we    = 1'b1;
      end
      OPC_OP:
      begin
        ctrl.reg_we    = 1'b1;
        ctrl.alu_ctl   = CTL_OP;
      end
      OPC_LUI:
      begin
        ctrl.reg_we    = 1'b1;
        ctrl.wb_sel    = WB_IMM;    // immediate goes straight to rd.
      end
      OPC_BRANCH:
      begin
        ctrl.alu_ctl   = CTL_BRANCH;
      end
      OPC_JALR:
      begin
        ctrl.reg_we    = 1'b1;
        ctrl.alu_b_sel = B_IMM;
        ctrl.wb_sel    = WB_PC4;
      end
      OPC_JAL:
      begin
        ctrl.reg_we    = 1'b1;
        ctrl.alu_a_sel = A_PC;
        ctrl.alu_b_sel = B_IMM;
        ctrl.wb_sel    = WB_PC4;
      end
      default:
      begin
        ctrl.illegal   = 1'b1;      // all enables stay low.
      end
    endcase
  end

endmodule

/* rv_ctrl_pkg.sv */
/*
 * Execute stage control and transport types. Select encodings for the
 * datapath muxes, the decoded control bundle and the request/result records.
 */

package rv_ctrl_pkg;

  typedef enum logic {
    A_RS1 = 1'b0,
    A_PC  = 1'b1
  } alu_a_sel_e;

  typedef enum logic {
    B_RS2 = 1'b0,
    B_IMM = 1'b1
  } alu_b_sel_e;

  // ALU class, refined by funct3/funct7 in the execute unit.
  typedef enum logic [1:0] {
    CTL_ADD    = 2'd0,
    CTL_OP_IMM = 2'd1,
    CTL_OP     = 2'd2,
    CTL_BRANCH = 2'd3
  } alu_ctl_e;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_DATA = 2'd1, // load data, not returned in this stage.
    WB_IMM  = 2'd2,
    WB_PC4  = 2'd3
  } wb_sel_e;

  typedef enum logic [1:0] {
    PC_PC4     = 2'd0,
    PC_PC_IMM  = 2'd1,
    PC_RS1_IMM = 2'd2
  } pc_sel_e;

  typedef struct packed {
    logic       reg_we;
    alu_a_sel_e alu_a_sel;
    alu_b_sel_e alu_b_sel;
    alu_ctl_e   alu_ctl;
    logic       mem_re;
    logic       mem_we;
    wb_sel_e    wb_sel;
    pc_sel_e    pc_sel;
    logic       illegal;
  } ctrl_t;

  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] pc;
    logic [31:0]                 inst;
    logic [rv_isa_pkg::XLEN-1:0] rs1_data;
    logic [rv_isa_pkg::XLEN-1:0] rs2_data;
  } exec_req_t;

  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0] next_pc;
    logic [4:0]                  rd_addr;
    logic                        rd_we;
    logic [rv_isa_pkg::XLEN-1:0] wb_data;
    logic [rv_isa_pkg::XLEN-1:0] mem_addr;
    logic [rv_isa_pkg::XLEN-1:0] store_data;
    logic                        mem_re;
    logic                        mem_we;
    logic                        illegal;
  } exec_res_t;

endpackage

/* rv_isa_pkg.sv */
/*
 * RV32I base ISA definitions. Holds the major opcodes, the funct3 codes for
 * ALU and branch instructions, and the ALU operations of the execute stage.
 */

package rv_isa_pkg;

  localparam int XLEN = 32; // data and address width.

  // major opcodes, inst[6:0].
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111, // fence, treated as a no-op.
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111
  } opcode_e;

  // funct3 of OP and OP_IMM.
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } alu_f3_e;

  // funct3 of BRANCH.
  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } branch_f3_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

endpackage
